/* src/uart_pkg.sv */
// shared bus, register and frame types; LC bits 1:0 hold the word length code (data bits - 5)
package uart_pkg;

	// DL1 and DL2 are only reachable while the divisor-latch bit is set
	typedef enum logic [2:0] {
		REG_DL1 = 3'd0,
		REG_IE  = 3'd1,
		REG_FC  = 3'd2,
		REG_LC  = 3'd3
	} reg_addr_e;

	localparam reg_addr_e REG_DL2 = REG_IE; // high divisor byte shares the IE address

	// line control and interrupt enable bit positions
	localparam int LC_STOP  = 2;
	localparam int LC_PEN   = 3;
	localparam int LC_DLAB  = 7;
	localparam int IE_ETBEI = 1;

	typedef enum logic [4:0] {
		IDLE,
		FIRST_READ,
		WAIT_ACK_1,
		WRITE_1,
		WAIT_ACK_2,
		WAIT_STATE_1,
		WRITE_2,
		WAIT_ACK_3,
		WAIT_STATE_2,
		WRITE_3,
		WAIT_ACK_4,
		WAIT_PRE_READ,
		READ_2,
		WAIT_ACK_5,
		WRITE_4,
		WAIT_ACK_6,
		WAIT_STATE_3,
		WRITE_5,
		WAIT_ACK_7,
		WAIT_PRE_READ_2,
		READ_3,
		WAIT_ACK_8,
		WRITE_6,
		WAIT_ACK_9,
		CONF_DONE
	} cfg_state_e;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		reg_addr_e  addr;
		logic [7:0] wdata;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] rdata;
	} wb_rsp_t;

	typedef struct packed {
		logic [15:0] divisor;
		logic [1:0]  data_bits;
		logic        two_stop;
		logic        parity_en;
	} frame_cfg_t;

endpackage

/* src/uart_regs.sv */
// register slave with no THR or LSR; writes to address 0 with the divisor latch clear are dropped
`timescale 1ns/100ps

module uart_regs import uart_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  wb_req_t    req_i,
	input  logic       tx_idle_i,
	output wb_rsp_t    rsp_o,
	output frame_cfg_t cfg_o,
	output logic       irq_o
);

	logic [7:0]  lc_q;
	logic [15:0] dl_q;
	logic [7:0]  fc_q;
	logic [7:0]  ie_q;
	logic        ack_q;
	logic [7:0]  rdata_q;
	logic [7:0]  rdata_nxt;
	logic        dlab;
	logic        access;

	assign dlab = lc_q[LC_DLAB];

	// the master drops stb before its next access, so one ack per strobe is enough
	assign access = req_i.cyc & req_i.stb & !ack_q;

	always_comb begin
		rdata_nxt = 8'h00;
		case (req_i.addr)
			REG_DL1: rdata_nxt = dlab ? dl_q[7:0] : 8'h00;
			REG_IE:  rdata_nxt = dlab ? dl_q[15:8] : ie_q;
			REG_FC:  rdata_nxt = fc_q;
			REG_LC:  rdata_nxt = lc_q;
			default: rdata_nxt = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			lc_q  <= 8'h03; // 8 data bits, one stop, no parity
			dl_q  <= 16'd1;
			fc_q  <= 8'h00;
			ie_q  <= 8'h00;
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
			if (access && req_i.we) begin
				case (req_i.addr)
					REG_DL1: begin
						if (dlab)
							dl_q[7:0] <= req_i.wdata;
					end
					REG_IE: begin
						if (dlab)
							dl_q[15:8] <= req_i.wdata;
						else
							ie_q <= req_i.wdata;
					end
					REG_FC:  fc_q <= req_i.wdata;
					REG_LC:  lc_q <= req_i.wdata;
					default: ;
				endcase
			end
		end
	end

	// read data goes out together with ack
	always_ff @(posedge clk) begin
		if (access)
			rdata_q <= rdata_nxt;
	end

	assign rsp_o = '{ack: ack_q, rdata: rdata_q};
	assign cfg_o = '{divisor: dl_q, data_bits: lc_q[1:0],
		two_stop: lc_q[LC_STOP], parity_en: lc_q[LC_PEN]};

	assign irq_o = ie_q[IE_ETBEI] & tx_idle_i; // transmit-empty interrupt only

endmodule

/* src/uart_config_seq.sv */
// one-shot bus master; a second start pulse after CONF_DONE is ignored until reset
`timescale 1ns/100ps

module uart_config_seq import uart_pkg::*; #(
	parameter int unsigned DIVISOR         = 16,  // clock cycles per bit, 1 to 65535
	parameter int unsigned N_DATA_BITS     = 8,   // 5 to 8
	parameter bit          PARITY_EN       = 1'b0,
	parameter bit          SINGLE_STOP_BIT = 1'b1
) (
	input  logic    clk,
	input  logic    rstn,
	input  logic    start_i,
	input  wb_rsp_t rsp_i,
	output wb_req_t req_o,
	output logic    config_done_o
);

	localparam logic [15:0] DIV_VAL  = 16'(DIVISOR);
	localparam logic [1:0]  WLS_CODE = 2'(N_DATA_BITS - 5);

	cfg_state_e state;
	cfg_state_e state_nxt;
	logic       ack_sampled;
	logic       advance;
	logic       issue;
	logic       waiting;
	logic [7:0] rd_data;
	logic [7:0] lc_fmt;

	// states are listed in walk order, so every move is one step forward
	always_comb begin
		case (state)
			IDLE: advance = start_i;
			WAIT_ACK_1, WAIT_ACK_2, WAIT_ACK_3, WAIT_ACK_4, WAIT_ACK_5,
			WAIT_ACK_6, WAIT_ACK_7, WAIT_ACK_8, WAIT_ACK_9: advance = ack_sampled;
			CONF_DONE: advance = 1'b0;
			default: advance = 1'b1;
		endcase
		state_nxt = advance ? cfg_state_e'(state + 5'd1) : state;
	end

	assign issue = state inside {FIRST_READ, WRITE_1, WRITE_2, WRITE_3, READ_2,
		WRITE_4, WRITE_5, READ_3, WRITE_6};
	assign waiting = state inside {WAIT_ACK_1, WAIT_ACK_2, WAIT_ACK_3, WAIT_ACK_4,
		WAIT_ACK_5, WAIT_ACK_6, WAIT_ACK_7, WAIT_ACK_8, WAIT_ACK_9};

	// frame format goes in while the other read bits are left alone
	always_comb begin
		lc_fmt          = rd_data;
		lc_fmt[1:0]     = WLS_CODE;
		lc_fmt[LC_STOP] = !SINGLE_STOP_BIT;
		lc_fmt[LC_PEN]  = PARITY_EN;
		lc_fmt[LC_DLAB] = 1'b0;
	end

	// issue and wait states of one access drive the same address, we and data
	always_comb begin
		req_o.addr  = REG_DL1;
		req_o.we    = 1'b0;
		req_o.wdata = 8'h00;
		case (state)
			FIRST_READ, WAIT_ACK_1, READ_2, WAIT_ACK_5: begin
				req_o.addr = REG_LC;
			end
			WRITE_1, WAIT_ACK_2: begin
				req_o.addr  = REG_LC;
				req_o.we    = 1'b1;
				req_o.wdata = rd_data | (8'd1 << LC_DLAB);
			end
			WRITE_2, WAIT_ACK_3: begin
				req_o.addr  = REG_DL2;
				req_o.we    = 1'b1;
				req_o.wdata = DIV_VAL[15:8];
			end
			WRITE_3, WAIT_ACK_4: begin
				req_o.addr  = REG_DL1;
				req_o.we    = 1'b1;
				req_o.wdata = DIV_VAL[7:0];
			end
			WRITE_4, WAIT_ACK_6: begin
				req_o.addr  = REG_LC;
				req_o.we    = 1'b1;
				req_o.wdata = lc_fmt;
			end
			WRITE_5, WAIT_ACK_7: begin
				req_o.addr = REG_FC;
				req_o.we   = 1'b1;
			end
			READ_3, WAIT_ACK_8: begin
				req_o.addr = REG_IE;
			end
			WRITE_6, WAIT_ACK_9: begin
				req_o.addr  = REG_IE;
				req_o.we    = 1'b1;
				req_o.wdata = rd_data | (8'd1 << IE_ETBEI);
			end
			default: ;
		endcase
	end

	// the request drops in the cycle the sampled ack shows up
	assign req_o.cyc = issue | (waiting & !ack_sampled);
	assign req_o.stb = issue | (waiting & !ack_sampled);

	assign config_done_o = (state == CONF_DONE);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= IDLE;
			ack_sampled <= 1'b0;
		end else begin
			state       <= state_nxt;
			ack_sampled <= rsp_i.ack;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_i.ack && !req_o.we)
			rd_data <= rsp_i.rdata; // read data is valid with ack
	end

endmodule

/* src/uart_tx_framer.sv */
// LSB-first framer, one bit per divisor cycles; a divisor of 0 gives 65536-cycle bits
`timescale 1ns/100ps

module uart_tx_framer import uart_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  frame_cfg_t cfg_i,
	input  logic       enable_i,
	input  logic [7:0] tx_data_i,
	input  logic       tx_valid_i,
	output logic       tx_o,
	output logic       tx_busy_o
);

	logic        busy_q;
	logic        tx_q;
	logic [15:0] baud_cnt;
	logic [3:0]  bits_left;
	logic [10:0] shift_q;
	logic [11:0] frame;
	logic [3:0]  n_data;
	logic [3:0]  n_bits;
	logic [7:0]  data_mask;
	logic        parity;
	logic        accept;
	logic        bit_end;

	assign n_data    = 4'd5 + 4'(cfg_i.data_bits);
	assign n_bits    = 4'd2 + n_data + 4'(cfg_i.parity_en) + 4'(cfg_i.two_stop);
	assign data_mask = 8'hff >> (2'd3 - cfg_i.data_bits);
	assign parity    = ^(tx_data_i & data_mask); // even parity over the used bits only

	assign accept  = enable_i & tx_valid_i & !busy_q;
	assign bit_end = busy_q && (baud_cnt == 16'd0);

	// unused data positions and everything above are ones, so the stop bits come for free
	always_comb begin
		frame = {3'b111, tx_data_i | ~data_mask, 1'b0};
		if (cfg_i.parity_en)
			frame[n_data + 4'd1] = parity;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			busy_q    <= 1'b0;
			tx_q      <= 1'b1;
			baud_cnt  <= 16'd0;
			bits_left <= 4'd0;
		end else if (accept) begin
			busy_q    <= 1'b1;
			tx_q      <= frame[0]; // start bit begins on the accepting edge
			baud_cnt  <= cfg_i.divisor - 16'd1;
			bits_left <= n_bits - 4'd1;
		end else if (bit_end) begin
			baud_cnt <= cfg_i.divisor - 16'd1;
			if (bits_left == 4'd0) begin
				busy_q <= 1'b0;
				tx_q   <= 1'b1;
			end else begin
				tx_q      <= shift_q[0];
				bits_left <= bits_left - 4'd1;
			end
		end else if (busy_q) begin
			baud_cnt <= baud_cnt - 16'd1;
		end
	end

	// remaining frame bits, shifted out at each bit boundary
	always_ff @(posedge clk) begin
		if (accept)
			shift_q <= frame[11:1];
		else if (bit_end)
			shift_q <= {1'b1, shift_q[10:1]};
	end

	assign tx_o      = tx_q;
	assign tx_busy_o = busy_q;

endmodule

/* src/uart_subsystem.sv */
// transmit-only UART; strobes before config_done_o or during a frame are dropped
`timescale 1ns/100ps

module uart_subsystem import uart_pkg::*; #(
	parameter int unsigned DIVISOR         = 16,
	parameter int unsigned N_DATA_BITS     = 8,
	parameter bit          PARITY_EN       = 1'b0,
	parameter bit          SINGLE_STOP_BIT = 1'b1
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic       start_config_i,
	input  logic [7:0] tx_data_i,
	input  logic       tx_valid_i,
	output logic       config_done_o,
	output logic       tx_o,
	output logic       tx_busy_o,
	output logic       irq_o
);

	wb_req_t    bus_req;
	wb_rsp_t    bus_rsp;
	frame_cfg_t frame_cfg;

	uart_config_seq #(
		.DIVISOR         (DIVISOR),
		.N_DATA_BITS     (N_DATA_BITS),
		.PARITY_EN       (PARITY_EN),
		.SINGLE_STOP_BIT (SINGLE_STOP_BIT)
	) u_config_seq (
		.clk           (clk),
		.rstn          (rstn),
		.start_i       (start_config_i),
		.rsp_i         (bus_rsp),
		.req_o         (bus_req),
		.config_done_o (config_done_o)
	);

	uart_regs u_regs (
		.clk       (clk),
		.rstn      (rstn),
		.req_i     (bus_req),
		.tx_idle_i (!tx_busy_o),
		.rsp_o     (bus_rsp),
		.cfg_o     (frame_cfg),
		.irq_o     (irq_o)
	);

	uart_tx_framer u_tx_framer (
		.clk        (clk),
		.rstn       (rstn),
		.cfg_i      (frame_cfg),
		.enable_i   (config_done_o), // divisor and format are final only after configuration
		.tx_data_i  (tx_data_i),
		.tx_valid_i (tx_valid_i),
		.tx_o       (tx_o),
		.tx_busy_o  (tx_busy_o)
	);

endmodule

/* verification/uart_subsystem_assertions.sv */
// bound into uart_subsystem; watches the internal bus and the serial line only while out of reset
`timescale 1ns/100ps

module uart_subsystem_assertions import uart_pkg::*; (
	input logic    clk,
	input logic    rstn,
	input wb_req_t req_i,
	input wb_rsp_t rsp_i,
	input logic    tx_i,
	input logic    tx_busy_i
);

	// the slave may only answer an access that is still being driven
	ack_needs_stb: assert property (@(posedge clk) disable iff (!rstn)
		rsp_i.ack |-> (req_i.cyc && req_i.stb))
		else $error("ack seen without an active cyc and stb");

	// after its one ack cycle the master leaves the bus idle for a cycle
	ack_single_cycle: assert property (@(posedge clk) disable iff (!rstn)
		rsp_i.ack |=> (!rsp_i.ack && !req_i.stb))
		else $error("ack stayed high for more than one cycle or stb was not dropped after it");

	ack_after_first_stb: assert property (@(posedge clk) disable iff (!rstn)
		$rose(req_i.stb) |=> rsp_i.ack)
		else $error("no ack one cycle after stb was first raised");

	idle_line_high: assert property (@(posedge clk) disable iff (!rstn)
		!tx_busy_i |-> tx_i)
		else $error("serial line low while the framer is idle");

endmodule

bind uart_subsystem uart_subsystem_assertions u_assertions (
	.clk       (clk),
	.rstn      (rstn),
	.req_i     (bus_req),
	.rsp_i     (bus_rsp),
	.tx_i      (tx_o),
	.tx_busy_i (tx_busy_o)
);

/* verification/tb_uart_subsystem.sv */
// trace file is read from verification/tx_trace.txt relative to the run directory; 7E2 format, divisor 8
`timescale 1ns/100ps

module tb_uart_subsystem;

	localparam int DIVISOR          = 8;
	localparam int FRAME_BITS       = 11;
	localparam int FRAME_CYCLES     = FRAME_BITS * DIVISOR;
	localparam int CONFIG_ALLOWANCE = 200;
	localparam int DROP_CYCLE       = 20; // inside the third bit of every odd frame
	localparam logic [31:0] SEED    = 32'h5cc6d135;

	logic       clk;
	logic       rstn;
	logic       start_config_i;
	logic [7:0] tx_data_i;
	logic       tx_valid_i;
	logic       config_done_o;
	logic       tx_o;
	logic       tx_busy_o;
	logic       irq_o;

	logic [7:0]  trace_byte[$];
	logic [10:0] trace_frame[$];
	int          mismatches = 0;
	int          problems = 0;
	int          cycles = 0;
	int          cycle_limit = CONFIG_ALLOWANCE;
	logic        done_seen = 1'b0;

	uart_subsystem #(
		.DIVISOR         (DIVISOR),
		.N_DATA_BITS     (7),
		.PARITY_EN       (1'b1),
		.SINGLE_STOP_BIT (1'b0)
	) u_dut (
		.clk            (clk),
		.rstn           (rstn),
		.start_config_i (start_config_i),
		.tx_data_i      (tx_data_i),
		.tx_valid_i     (tx_valid_i),
		.config_done_o  (config_done_o),
		.tx_o           (tx_o),
		.tx_busy_o      (tx_busy_o),
		.irq_o          (irq_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic note_mismatch(input string msg);
		$display("FAIL %0d ns: %s", $time, msg);
		mismatches++;
	endtask

	task automatic note_problem(input string msg);
		$display("error: %s", msg);
		problems++;
	endtask

	// frame in line order, first bit on the wire in the top position
	function automatic logic [10:0] build_frame(input logic [7:0] b);
		logic [10:0] f;
		logic        p;
		p = 1'b0;
		f[10] = 1'b0;
		for (int k = 0; k < 7; k++) begin
			f[9 - k] = b[k];
			p ^= b[k];
		end
		f[2:0] = {p, 2'b11};
		return f;
	endfunction

	task automatic read_trace();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  b;
		logic [10:0] bits;
		fd = $fopen("verification/tx_trace.txt", "r");
		if (fd == 0) begin
			note_problem("could not open verification/tx_trace.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%h %b", b, bits);
					if (n != 2)
						note_problem($sformatf("unreadable trace line: %s", line));
					else if (bits != build_frame(b))
						note_problem($sformatf("trace frame for byte %02h breaks the 7E2 format", b));
					else begin
						trace_byte.push_back(b);
						trace_frame.push_back(bits);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic send_frame(input int idx);
		logic [10:0] expected;
		logic [10:0] captured;
		expected = trace_frame[idx];
		captured = '1;
		tx_data_i = trace_byte[idx];
		tx_valid_i = 1'b1;
		@(posedge clk);
		#1;
		assert (tx_busy_o) else note_mismatch("tx_busy_o did not rise on the accepting edge");
		for (int c = 0; c < FRAME_CYCLES; c++) begin
			if (c > 0) begin
				@(posedge clk);
				#1;
			end
			tx_valid_i = (c == DROP_CYCLE) && (idx % 2 == 1); // strobe while busy, must be dropped
			tx_data_i = 8'($urandom);
			assert (tx_busy_o) else note_mismatch($sformatf("tx_busy_o low in frame cycle %0d", c));
			assert (tx_o == expected[10 - c / DIVISOR])
				else note_mismatch($sformatf("tx_o wrong in frame cycle %0d of byte %02h",
					c, trace_byte[idx]));
			if (c % DIVISOR == DIVISOR / 2)
				captured[10 - c / DIVISOR] = tx_o;
		end
		@(posedge clk);
		#1;
		assert (!tx_busy_o) else note_mismatch("tx_busy_o still high after the last stop bit");
		assert (captured == expected)
			else note_mismatch($sformatf("byte %02h sampled as %b, expected %b",
				trace_byte[idx], captured, expected));
	endtask

	// irq and done rules hold on every cycle, not only inside frames
	always @(negedge clk) begin
		if (rstn) begin
			assert (!(done_seen && !config_done_o)) else note_mismatch("config_done_o fell again");
			if (config_done_o)
				done_seen = 1'b1;
			if (config_done_o && !tx_busy_o)
				assert (irq_o) else note_mismatch("irq_o low while configured and idle");
			if (tx_busy_o)
				assert (!irq_o) else note_mismatch("irq_o high during a frame");
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(SEED));
		rstn = 1'b0;
		start_config_i = 1'b0;
		tx_data_i = 8'h00;
		tx_valid_i = 1'b0;
		read_trace();
		cycle_limit = CONFIG_ALLOWANCE + trace_byte.size() * (FRAME_CYCLES + 4);
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;
		@(posedge clk);
		#1;
		assert (!config_done_o && !tx_busy_o && !irq_o && tx_o)
			else note_mismatch("outputs not at their reset values");

		// the framer is not enabled before configuration
		tx_data_i = 8'($urandom);
		tx_valid_i = 1'b1;
		@(posedge clk);
		#1;
		tx_valid_i = 1'b0;
		repeat (4) begin
			assert (!tx_busy_o) else note_mismatch("strobe accepted before config_done_o");
			@(posedge clk);
			#1;
		end

		start_config_i = 1'b1;
		@(posedge clk);
		#1;
		start_config_i = 1'b0;
		while (!config_done_o) begin
			@(posedge clk);
			#1;
		end

		if (trace_byte.size() == 0)
			note_problem("no usable lines in the trace file");
		for (int i = 0; i < trace_byte.size(); i++)
			send_frame(i);

		$display("closing report: %0d value mismatches, %0d other errors", mismatches, problems);
		if (mismatches == 0 && problems == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
src/uart_pkg.sv
src/uart_regs.sv
src/uart_config_seq.sv
src/uart_tx_framer.sv
src/uart_subsystem.sv
verification/uart_subsystem_assertions.sv
verification/tb_uart_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the UART subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
	--top-module tb_uart_subsystem -o sim_uart_subsystem

out=$(./obj_dir/sim_uart_subsystem 2>&1)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
	exit 0
else
	echo "simulation did not report a pass"
	exit 1
fi

/* verification/tx_trace.txt */
# byte (hex), then the frame bits in line order: start, 7 data bits LSB first, even parity, 2 stop
# bit 7 of each byte is not sent and is left out of the parity
55 01010101011
00 00000000011
7f 01111111111
ff 01111111111
80 00000000011
01 01000000111
40 00000001111
3c 00011110011
a5 01010010111
12 00100100011
